// File: compile.f
ray_tri_pkg.sv
delay_line.sv
edge_setup.sv
cross_product.sv
dot_product.sv
contact_detect.sv
contact_point.sv
ray_tri_intersect.sv
ray_tri_assertions.sv
ray_tri_tb.sv

// File: contact_detect.sv
`default_nettype none

module contact_detect (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic signed [ray_tri_pkg::dot_w-1:0] det,
  input  logic signed [ray_tri_pkg::dot_w-1:0] u_num,
  input  logic signed [ray_tri_pkg::dot_w-1:0] v_num,
  input  logic signed [ray_tri_pkg::dot_w-1:0] t_num,
  output logic                                 hit
);

  // numerators scaled by sign(det), two extra bits for negation and u+v
  logic signed [ray_tri_pkg::dot_w+1:0] u_s;
  logic signed [ray_tri_pkg::dot_w+1:0] v_s;
  logic signed [ray_tri_pkg::dot_w+1:0] t_s;
  logic signed [ray_tri_pkg::dot_w+1:0] uv_s;
  logic signed [ray_tri_pkg::dot_w+1:0] det_abs;

  // negative determinant means the ray sees the back face
  always_comb begin
    if (det[ray_tri_pkg::dot_w-1]) begin
      u_s     = -u_num;
      v_s     = -v_num;
      t_s     = -t_num;
      det_abs = -det;
    end else begin
      u_s     = u_num;
      v_s     = v_num;
      t_s     = t_num;
      det_abs = det;
    end
    uv_s = u_s + v_s;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= (det != '0) && (u_s >= 0) && (v_s >= 0) &&  // inside both edges
             (uv_s <= det_abs) && (t_s > 0);               // third edge, in front
    end
  end

endmodule

`default_nettype wire

// File: contact_point.sv
`default_nettype none

module contact_point (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  ray_tri_pkg::coord_vec_u               orig,
  input  ray_tri_pkg::coord_vec_u               dir,
  input  logic signed [ray_tri_pkg::dot_w-1:0] t_num,
  input  logic signed [ray_tri_pkg::dot_w-1:0] det,
  output ray_tri_pkg::point_vec_u               point
);

  // coord_w x dot_w products
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] od_x;
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] od_y;
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] od_z;
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] dt_x;
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] dt_y;
  logic signed [ray_tri_pkg::coord_w+ray_tri_pkg::dot_w-1:0] dt_z;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      od_x <= '0;
      od_y <= '0;
      od_z <= '0;
      dt_x <= '0;
      dt_y <= '0;
      dt_z <= '0;
    end else begin
      od_x <= orig.v.x * det;   // origin scaled to the common denominator
      od_y <= orig.v.y * det;
      od_z <= orig.v.z * det;
      dt_x <= dir.v.x * t_num;
      dt_y <= dir.v.y * t_num;
      dt_z <= dir.v.z * t_num;
    end
  end

  // w of the homogeneous point is det, carried alongside at the top
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      point <= '0;
    end else begin
      point.v.x <= od_x + dt_x;
      point.v.y <= od_y + dt_y;
      point.v.z <= od_z + dt_z;
    end
  end

endmodule

`default_nettype wire

// File: cross_product.sv
`default_nettype none

module cross_product (
  input  logic                   clk,
  input  logic                   arst_n,
  input  ray_tri_pkg::edge_vec_u  a,
  input  ray_tri_pkg::edge_vec_u  b,
  output ray_tri_pkg::cross_vec_u result
);

  // partial products, full 2*edge_w precision
  logic signed [2*ray_tri_pkg::edge_w-1:0] ay_bz;
  logic signed [2*ray_tri_pkg::edge_w-1:0] az_by;
  logic signed [2*ray_tri_pkg::edge_w-1:0] az_bx;
  logic signed [2*ray_tri_pkg::edge_w-1:0] ax_bz;
  logic signed [2*ray_tri_pkg::edge_w-1:0] ax_by;
  logic signed [2*ray_tri_pkg::edge_w-1:0] ay_bx;

  // stage one: six multipliers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ay_bz <= '0;
      az_by <= '0;
      az_bx <= '0;
      ax_bz <= '0;
      ax_by <= '0;
      ay_bx <= '0;
    end else begin
      ay_bz <= a.v.y * b.v.z;
      az_by <= a.v.z * b.v.y;
      az_bx <= a.v.z * b.v.x;
      ax_bz <= a.v.x * b.v.z;
      ax_by <= a.v.x * b.v.y;
      ay_bx <= a.v.y * b.v.x;
    end
  end

  // stage two: differences, one extra bit so nothing wraps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result.v.x <= ay_bz - az_by;
      result.v.y <= az_bx - ax_bz;
      result.v.z <= ax_by - ay_bx;
    end
  end

endmodule

`default_nettype wire

// File: delay_line.sv
`default_nettype none

module delay_line #(
  parameter int DEPTH = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  logic [WIDTH-1:0] stage [DEPTH];  // stage[0] takes d, last stage drives q

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: dot_product.sv
`default_nettype none

module dot_product (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  ray_tri_pkg::edge_vec_u                  a,
  input  ray_tri_pkg::cross_vec_u                 b,
  output logic signed [ray_tri_pkg::dot_w-1:0]   result
);

  // edge_w x cross_w products
  logic signed [ray_tri_pkg::edge_w+ray_tri_pkg::cross_w-1:0] px;
  logic signed [ray_tri_pkg::edge_w+ray_tri_pkg::cross_w-1:0] py;
  logic signed [ray_tri_pkg::edge_w+ray_tri_pkg::cross_w-1:0] pz;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      px <= '0;
      py <= '0;
      pz <= '0;
    end else begin
      px <= a.v.x * b.v.x;
      py <= a.v.y * b.v.y;
      pz <= a.v.z * b.v.z;
    end
  end

  // two guard bits cover the three-term sum
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result <= px + py + pz;
    end
  end

endmodule

`default_nettype wire

// File: edge_setup.sv
`default_nettype none

module edge_setup (
  input  logic                   clk,
  input  logic                   arst_n,
  input  ray_tri_pkg::coord_vec_u v0,
  input  ray_tri_pkg::coord_vec_u v1,
  input  ray_tri_pkg::coord_vec_u v2,
  input  ray_tri_pkg::coord_vec_u orig,
  output ray_tri_pkg::edge_vec_u  edge1,
  output ray_tri_pkg::edge_vec_u  edge2,
  output ray_tri_pkg::edge_vec_u  tvec
);

  // operands are signed, so each difference is sign extended to edge_w
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      edge1 <= '0;
      edge2 <= '0;
      tvec  <= '0;
    end else begin
      edge1.v.x <= v1.v.x - v0.v.x;  // v1 - v0
      edge1.v.y <= v1.v.y - v0.v.y;
      edge1.v.z <= v1.v.z - v0.v.z;

      edge2.v.x <= v2.v.x - v0.v.x;  // v2 - v0
      edge2.v.y <= v2.v.y - v0.v.y;
      edge2.v.z <= v2.v.z - v0.v.z;

      tvec.v.x  <= orig.v.x - v0.v.x;  // origin relative to v0
      tvec.v.y  <= orig.v.y - v0.v.y;
      tvec.v.z  <= orig.v.z - v0.v.z;
    end
  end

endmodule

`default_nettype wire

// File: ray_tri_assertions.sv
`default_nettype none

module ray_tri_assertions (
  input logic                          clk,
  input logic                          arst_n,
  input logic                          ray_valid,
  input logic [ray_tri_pkg::sid_w-1:0] sid_in,
  input logic                          result_valid,
  input logic [ray_tri_pkg::sid_w-1:0] sid_out,
  input logic                          hit
);

  logic [3:0] settled_cnt;  // edges since reset release, stops at 7
  logic       settled;

  // the pipeline holds only post-reset samples once seven edges have passed
  assign settled = (settled_cnt >= 4'd7);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      settled_cnt <= '0;
    end else if (!settled) begin
      settled_cnt <= settled_cnt + 4'd1;
    end
  end

  reset_quiet: assert property (@(posedge clk) !arst_n |-> (!result_valid && !hit))
    else $error("result_valid or hit is set while reset is asserted");

  valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    settled |-> (result_valid == $past(ray_valid, 7)))
    else $error("result_valid does not follow ray_valid by seven cycles");

  sid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (settled && result_valid) |-> (sid_out == $past(sid_in, 7)))
    else $error("sid_out does not match the tag driven seven cycles earlier");

  hit_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    hit |-> result_valid)
    else $error("hit is set without result_valid");

endmodule

bind ray_tri_intersect ray_tri_assertions u_assertions (
  .clk(clk),
  .arst_n(arst_n),
  .ray_valid(ray_valid),
  .sid_in(sid_in),
  .result_valid(result_valid),
  .sid_out(sid_out),
  .hit(hit)
);

`default_nettype wire

// File: ray_tri_intersect.sv
`default_nettype none

module ray_tri_intersect (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 ray_valid,
  input  ray_tri_pkg::coord_vec_u               v0,
  input  ray_tri_pkg::coord_vec_u               v1,
  input  ray_tri_pkg::coord_vec_u               v2,
  input  ray_tri_pkg::coord_vec_u               orig,
  input  ray_tri_pkg::coord_vec_u               dir,
  input  logic [ray_tri_pkg::sid_w-1:0]        sid_in,
  output logic                                 result_valid,
  output logic [ray_tri_pkg::sid_w-1:0]        sid_out,
  output logic                                 hit,
  output ray_tri_pkg::cross_vec_u               norm,
  output logic signed [ray_tri_pkg::dot_w-1:0] det,
  output logic signed [ray_tri_pkg::dot_w-1:0] t_num,
  output ray_tri_pkg::point_vec_u               point
);

  ray_tri_pkg::edge_vec_u  edge1, edge2, tvec;     // setup stage out
  ray_tri_pkg::edge_vec_u  edge1_d, edge2_d, tvec_d;
  ray_tri_pkg::coord_vec_u dir_d1;
  ray_tri_pkg::edge_vec_u  dir_e1, dir_e3;         // dir widened to edge_w
  ray_tri_pkg::cross_vec_u pvec, qvec, norm_raw;
  ray_tri_pkg::coord_vec_u orig_d5, dir_d5;
  logic signed [ray_tri_pkg::dot_w-1:0] det_raw, u_num, v_num, t_raw;
  logic                                 hit_raw;

  edge_setup u_setup (.clk(clk), .arst_n(arst_n), .v0(v0), .v1(v1), .v2(v2), .orig(orig),
                      .edge1(edge1), .edge2(edge2), .tvec(tvec));

  delay_line #(.DEPTH(ray_tri_pkg::setup_lat), .WIDTH(3*ray_tri_pkg::coord_w)) u_dir_d1 (
    .clk(clk), .arst_n(arst_n), .d(dir.bits), .q(dir_d1.bits));

  // sign extension of dir for the cross stage
  assign dir_e1.v.x = dir_d1.v.x;
  assign dir_e1.v.y = dir_d1.v.y;
  assign dir_e1.v.z = dir_d1.v.z;

  cross_product u_pvec (.clk(clk), .arst_n(arst_n), .a(dir_e1), .b(edge2), .result(pvec));
  cross_product u_qvec (.clk(clk), .arst_n(arst_n), .a(tvec), .b(edge1), .result(qvec));
  cross_product u_norm (.clk(clk), .arst_n(arst_n), .a(edge1), .b(edge2), .result(norm_raw));

  // operands that meet pvec and qvec at the dot stage
  delay_line #(.DEPTH(ray_tri_pkg::cross_lat), .WIDTH(3*ray_tri_pkg::edge_w)) u_e1_d (
    .clk(clk), .arst_n(arst_n), .d(edge1.bits), .q(edge1_d.bits));
  delay_line #(.DEPTH(ray_tri_pkg::cross_lat), .WIDTH(3*ray_tri_pkg::edge_w)) u_e2_d (
    .clk(clk), .arst_n(arst_n), .d(edge2.bits), .q(edge2_d.bits));
  delay_line #(.DEPTH(ray_tri_pkg::cross_lat), .WIDTH(3*ray_tri_pkg::edge_w)) u_tv_d (
    .clk(clk), .arst_n(arst_n), .d(tvec.bits), .q(tvec_d.bits));
  delay_line #(.DEPTH(ray_tri_pkg::cross_lat), .WIDTH(3*ray_tri_pkg::edge_w)) u_dir_d3 (
    .clk(clk), .arst_n(arst_n), .d(dir_e1.bits), .q(dir_e3.bits));

  dot_product u_det (.clk(clk), .arst_n(arst_n), .a(edge1_d), .b(pvec), .result(det_raw));
  dot_product u_unum (.clk(clk), .arst_n(arst_n), .a(tvec_d), .b(pvec), .result(u_num));
  dot_product u_vnum (.clk(clk), .arst_n(arst_n), .a(dir_e3), .b(qvec), .result(v_num));
  dot_product u_tnum (.clk(clk), .arst_n(arst_n), .a(edge2_d), .b(qvec), .result(t_raw));

  contact_detect u_detect (.clk(clk), .arst_n(arst_n), .det(det_raw), .u_num(u_num),
                           .v_num(v_num), .t_num(t_raw), .hit(hit_raw));

  // ray re-read at the dot stage output
  delay_line #(
    .DEPTH(ray_tri_pkg::setup_lat + ray_tri_pkg::cross_lat + ray_tri_pkg::dot_lat),
    .WIDTH(3*ray_tri_pkg::coord_w)
  ) u_orig_d5 (.clk(clk), .arst_n(arst_n), .d(orig.bits), .q(orig_d5.bits));
  delay_line #(
    .DEPTH(ray_tri_pkg::setup_lat + ray_tri_pkg::cross_lat + ray_tri_pkg::dot_lat),
    .WIDTH(3*ray_tri_pkg::coord_w)
  ) u_dir_d5 (.clk(clk), .arst_n(arst_n), .d(dir.bits), .q(dir_d5.bits));

  contact_point u_point (.clk(clk), .arst_n(arst_n), .orig(orig_d5), .dir(dir_d5),
                         .t_num(t_raw), .det(det_raw), .point(point));

  // output alignment to total_lat
  delay_line #(
    .DEPTH(ray_tri_pkg::total_lat - ray_tri_pkg::setup_lat - ray_tri_pkg::cross_lat),
    .WIDTH(3*ray_tri_pkg::cross_w)
  ) u_norm_d (.clk(clk), .arst_n(arst_n), .d(norm_raw.bits), .q(norm.bits));
  delay_line #(.DEPTH(ray_tri_pkg::point_lat), .WIDTH(ray_tri_pkg::dot_w)) u_det_d (
    .clk(clk), .arst_n(arst_n), .d(det_raw), .q(det));
  delay_line #(.DEPTH(ray_tri_pkg::point_lat), .WIDTH(ray_tri_pkg::dot_w)) u_tnum_d (
    .clk(clk), .arst_n(arst_n), .d(t_raw), .q(t_num));
  delay_line #(
    .DEPTH(ray_tri_pkg::point_lat - ray_tri_pkg::detect_lat),
    .WIDTH(1)
  ) u_hit_d (.clk(clk), .arst_n(arst_n), .d(hit_raw), .q(hit));

  delay_line #(.DEPTH(ray_tri_pkg::total_lat), .WIDTH(1)) u_valid_d (
    .clk(clk), .arst_n(arst_n), .d(ray_valid), .q(result_valid));
  delay_line #(.DEPTH(ray_tri_pkg::total_lat), .WIDTH(ray_tri_pkg::sid_w)) u_sid_d (
    .clk(clk), .arst_n(arst_n), .d(sid_in), .q(sid_out));

endmodule

`default_nettype wire

// File: ray_tri_pkg.sv
`default_nettype none

package ray_tri_pkg;

  localparam int coord_w = 16;  // signed input coordinate
  localparam int edge_w  = 17;  // difference of two coordinates
  localparam int cross_w = 35;  // edge x edge, plus one bit for the difference
  localparam int dot_w   = 54;  // edge . cross, summed over three terms
  localparam int point_w = 72;  // homogeneous point component
  localparam int sid_w   = 32;

  // pipeline depth of each stage
  localparam int setup_lat  = 1;
  localparam int cross_lat  = 2;
  localparam int dot_lat    = 2;
  localparam int detect_lat = 1;
  localparam int point_lat  = 2;
  localparam int total_lat  = setup_lat + cross_lat + dot_lat + point_lat;

  typedef struct packed {
    logic signed [coord_w-1:0] x;
    logic signed [coord_w-1:0] y;
    logic signed [coord_w-1:0] z;
  } coord_vec_s;

  typedef union packed {
    coord_vec_s           v;     // per-component view for arithmetic
    logic [3*coord_w-1:0] bits;  // flat view for delay lines
  } coord_vec_u;

  typedef struct packed {
    logic signed [edge_w-1:0] x;
    logic signed [edge_w-1:0] y;
    logic signed [edge_w-1:0] z;
  } edge_vec_s;

  typedef union packed {
    edge_vec_s           v;
    logic [3*edge_w-1:0] bits;
  } edge_vec_u;

  typedef struct packed {
    logic signed [cross_w-1:0] x;
    logic signed [cross_w-1:0] y;
    logic signed [cross_w-1:0] z;
  } cross_vec_s;

  typedef union packed {
    cross_vec_s           v;
    logic [3*cross_w-1:0] bits;
  } cross_vec_u;

  typedef struct packed {
    logic signed [point_w-1:0] x;
    logic signed [point_w-1:0] y;
    logic signed [point_w-1:0] z;
  } point_vec_s;

  typedef union packed {
    point_vec_s           v;
    logic [3*point_w-1:0] bits;
  } point_vec_u;

endpackage

`default_nettype wire

// File: ray_tri_tb.sv
`default_nettype none

module ray_tri_tb;

  localparam int period     = 20;
  localparam int latency    = 7;
  localparam int n_directed = 6;
  localparam int n_extreme  = 21;   // 20 random corner items plus one fixed
  localparam int n_stream   = 300;
  localparam int n_gapped   = 100;
  localparam int max_gap    = 3;
  localparam int n_before   = 5;    // items lost to the mid-stream reset
  localparam int n_after    = 10;
  localparam int n_items    = n_directed + n_extreme + n_stream + n_gapped + n_before + n_after;
  localparam int budget     = 16 + latency + n_items + n_gapped * max_gap + 3 + 1 + 20 + 50;

  typedef struct {
    logic [31:0]         sid;
    logic                hit;
    logic signed [127:0] nx, ny, nz, det, t, px, py, pz;
    longint              cyc;   // cycle count when the item was driven
  } expect_t;

  logic                                 clk = 1'b0;
  logic                                 arst_n;
  logic                                 ray_valid;
  ray_tri_pkg::coord_vec_u              v0, v1, v2, orig, dir;
  logic [ray_tri_pkg::sid_w-1:0]        sid_in;
  logic                                 result_valid;
  logic [ray_tri_pkg::sid_w-1:0]        sid_out;
  logic                                 hit;
  ray_tri_pkg::cross_vec_u              norm;
  logic signed [ray_tri_pkg::dot_w-1:0] det, t_num;
  ray_tri_pkg::point_vec_u              point;

  integer      seed = 32'h0890b445;
  longint      cyc = 0;
  int unsigned next_sid = 0;
  bit          passed = 1'b0;
  bit          fail_shown = 1'b0;
  expect_t     exp_q[$];

  always #(period / 2) clk = ~clk;

  ray_tri_intersect dut (
    .clk(clk), .arst_n(arst_n), .ray_valid(ray_valid),
    .v0(v0), .v1(v1), .v2(v2), .orig(orig), .dir(dir), .sid_in(sid_in),
    .result_valid(result_valid), .sid_out(sid_out), .hit(hit), .norm(norm),
    .det(det), .t_num(t_num), .point(point)
  );

  task automatic stop_run(input string why);
    fail_shown = 1'b1;
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic signed [127:0] exp,
                             input logic signed [127:0] got);
    assert (got == exp) else begin
      $display("error at time %0t: %s expected %0d got %0d", $time, name, exp, got);
      stop_run("output mismatch");
    end
  endtask

  function automatic logic signed [127:0] component_of(input ray_tri_pkg::coord_vec_u c,
                                                      input int i);
    case (i)
      0:       component_of = $signed(c.v.x);
      1:       component_of = $signed(c.v.y);
      default: component_of = $signed(c.v.z);
    endcase
  endfunction

  // Moller-Trumbore at full precision without the division
  function automatic expect_t predict(input ray_tri_pkg::coord_vec_u p0, p1, p2, o, d);
    logic signed [127:0] e1[3], e2[3], tv[3], dv[3], ov[3], pv[3], qv[3];
    logic signed [127:0] u, v, s;
    expect_t r;
    for (int i = 0; i < 3; i++) begin
      e1[i] = component_of(p1, i) - component_of(p0, i);
      e2[i] = component_of(p2, i) - component_of(p0, i);
      tv[i] = component_of(o, i) - component_of(p0, i);
      dv[i] = component_of(d, i);
      ov[i] = component_of(o, i);
    end
    pv[0] = dv[1] * e2[2] - dv[2] * e2[1];  // dir x edge2
    pv[1] = dv[2] * e2[0] - dv[0] * e2[2];
    pv[2] = dv[0] * e2[1] - dv[1] * e2[0];
    qv[0] = tv[1] * e1[2] - tv[2] * e1[1];  // tvec x edge1
    qv[1] = tv[2] * e1[0] - tv[0] * e1[2];
    qv[2] = tv[0] * e1[1] - tv[1] * e1[0];
    r.nx  = e1[1] * e2[2] - e1[2] * e2[1];
    r.ny  = e1[2] * e2[0] - e1[0] * e2[2];
    r.nz  = e1[0] * e2[1] - e1[1] * e2[0];
    r.det = e1[0] * pv[0] + e1[1] * pv[1] + e1[2] * pv[2];
    u     = tv[0] * pv[0] + tv[1] * pv[1] + tv[2] * pv[2];
    v     = dv[0] * qv[0] + dv[1] * qv[1] + dv[2] * qv[2];
    r.t   = e2[0] * qv[0] + e2[1] * qv[1] + e2[2] * qv[2];
    s     = (r.det < 0) ? -128'sd1 : 128'sd1;
    r.hit = (r.det != 0) && (u * s >= 0) && (v * s >= 0) &&
            ((u + v) * s <= r.det * s) && (r.t * s > 0);
    r.px  = ov[0] * r.det + dv[0] * r.t;  // homogeneous point with det as w
    r.py  = ov[1] * r.det + dv[1] * r.t;
    r.pz  = ov[2] * r.det + dv[2] * r.t;
    r.sid = '0;
    r.cyc = 0;
    return r;
  endfunction

  function automatic ray_tri_pkg::coord_vec_u vec(input int x, input int y, input int z);
    ray_tri_pkg::coord_vec_u r;
    r.v.x = 16'(x);
    r.v.y = 16'(y);
    r.v.z = 16'(z);
    return r;
  endfunction

  // mode 0 is full range, mode 1 a small range for frequent hits and mode 2 the corners
  function automatic ray_tri_pkg::coord_vec_u random_vec(input int mode);
    logic signed [15:0] c[3];
    for (int i = 0; i < 3; i++) begin
      case (mode)
        0:       c[i] = 16'($random(seed));
        1:       c[i] = 16'($random(seed) % 64);
        default: c[i] = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000;
      endcase
    end
    return vec(c[0], c[1], c[2]);
  endfunction

  // want_hit 2 means any outcome is fine
  task automatic issue(input ray_tri_pkg::coord_vec_u p0, p1, p2, o, d, input int want_hit);
    expect_t e;
    @(negedge clk);
    v0        = p0;
    v1        = p1;
    v2        = p2;
    orig      = o;
    dir       = d;
    sid_in    = next_sid;
    ray_valid = 1'b1;
    e         = predict(p0, p1, p2, o, d);
    e.sid     = next_sid;
    e.cyc     = cyc;
    if (want_hit != 2) begin
      assert (int'(e.hit) == want_hit) else stop_run("directed item misses its intended outcome");
    end
    exp_q.push_back(e);
    next_sid = next_sid + 32'h0001_0003;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      ray_valid = 1'b0;
      orig      = random_vec(0);  // origin carries junk between items
      dir       = '0;             // zero direction gives det 0 and no hit
    end
  endtask

  task automatic random_item(input int mode);
    issue(random_vec(mode), random_vec(mode), random_vec(mode), random_vec(mode),
          random_vec(mode), 2);
  endtask

  always @(posedge clk) begin
    expect_t e;
    cyc <= cyc + 1;
    if (!arst_n) begin
      assert (!result_valid && !hit) else stop_run("result_valid or hit is set during reset");
    end else if (result_valid) begin
      if (exp_q.size() == 0) begin
        stop_run("result_valid is set with no item outstanding");
      end else begin
        e = exp_q.pop_front();
        check_value("latency", latency, cyc - e.cyc);
        check_value("sid_out", e.sid, sid_out);
        check_value("hit", e.hit, hit);
        check_value("norm.x", e.nx, norm.v.x);
        check_value("norm.y", e.ny, norm.v.y);
        check_value("norm.z", e.nz, norm.v.z);
        check_value("det", e.det, det);
        check_value("t_num", e.t, t_num);
        check_value("point.x", e.px, point.v.x);
        check_value("point.y", e.py, point.v.y);
        check_value("point.z", e.pz, point.v.z);
      end
    end
  end

  initial begin
    #(budget * period);
    stop_run("results stopped arriving before the watchdog limit");
  end

  initial begin
    arst_n    = 1'b0;
    ray_valid = 1'b0;
    v0        = '0;
    v1        = '0;
    v2        = '0;
    orig      = '0;
    dir       = '0;
    sid_in    = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // triangle in the plane z = 50 and a ray along +z
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(0, 0, 0), vec(0, 0, 10), 1);
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(-150, 0, 0), vec(0, 0, 10), 0);   // u below zero
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(0, -150, 0), vec(0, 0, 10), 0);   // v below zero
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(100, 100, 0), vec(0, 0, 10), 0);  // u + v past the third edge
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(0, 0, 100), vec(0, 0, 10), 0);    // triangle behind the origin
    issue(vec(-100, -100, 50), vec(100, -100, 50), vec(0, 100, 50),
          vec(0, 0, 0), vec(10, 0, 0), 0);      // ray parallel to the plane so det is zero

    issue(vec(-32768, -32768, -32768), vec(32767, -32768, 32767), vec(-32768, 32767, 32767),
          vec(32767, 32767, -32768), vec(-32768, -32768, -32768), 2);
    repeat (n_extreme - 1) random_item(2);
    idle(2);

    for (int i = 0; i < n_stream; i++) begin
      random_item(i % 2);
    end

    for (int i = 0; i < n_gapped; i++) begin
      random_item(1);
      idle($unsigned($random(seed)) % (max_gap + 1));
    end

    // reset lands while items are still in the pipeline
    repeat (n_before) random_item(1);
    @(negedge clk);
    arst_n    = 1'b0;
    ray_valid = 1'b0;
    dir       = '0;
    exp_q.delete();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    repeat (n_after) random_item(1);
    idle(1);

    while (exp_q.size() != 0) @(negedge clk);
    idle(20);  // a stray late result would still reach the checker
    passed = 1'b1;
    $display("TEST PASS");
    $finish;
  end

  final begin
    if (!passed && !fail_shown) begin
      $display("TEST FAIL");
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ray/triangle testbench with Verilator, result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ray_tri_tb \
    -Mdir obj_dir -o ray_tri_sim -f compile.f > sim.log 2>&1 \
  && ./obj_dir/ray_tri_sim >> sim.log 2>&1 \
  || echo "%Error: build or simulation exited with a failing status" >> sim.log

grep -q -e "TEST FAIL" -e "^%Error" sim.log \
  && { echo "simulation failed, see sim.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
